/* index_arith.sv */
module index_arith
	import pkg_index::*;
(
	input	logic			clock,
	input	logic			reset,
	input	logic			stall,
	input	logic			req,
	input	logic			masked_read,
	input	logic			slice,
	input	logic			busy,
	input	index_src_t		sel_a,
	input	index_src_t		sel_b,
	input	index_src_t		sel_c,
	input	logic			swap,
	input	logic			sign,
	input	index_t			index,
	input	index_t			window,
	input	index_t			length,
	input	index_t			lane_id,
	input	index_t			thread_id,
	input	index_t			constant,
	input	mask_t			mask,
	index_cmd_if.arith		cmd
);

	logic		accept;
	index_t		op_a;
	index_t		op_b;
	index_t		op_c;
	index_t		product;
	index_t		base_val;
	req_kind_t	kind_val;

	function automatic index_t pick_operand(
		input index_src_t	src,
		input index_t		tid,
		input index_t		lid,
		input index_t		cval,
		input index_t		orig
	);
		case (src)
			SRC_THREAD:	return tid;
			SRC_LANE:	return lid;
			SRC_CONST:	return cval;
			SRC_ORIG:	return orig;
			default:	return '0;
		endcase
	endfunction

	assign accept	= req & ~stall & ~busy;

	assign op_a		= pick_operand(sel_a, thread_id, lane_id, constant, index);
	assign op_b		= pick_operand(sel_b, thread_id, lane_id, constant, index);
	assign op_c		= pick_operand(sel_c, thread_id, lane_id, constant, index);

	assign product	= op_a * op_b;		// Modulo 256

	// a*b+c, a*b-c or c-a*b
	assign base_val	= !sign ? product + op_c :
						!swap ? product - op_c :
						op_c - product;

	// Masked wins over slice
	assign kind_val	= masked_read ? KIND_MASKED :
						slice ? KIND_SLICE :
						KIND_SINGLE;

	// Valid pulse, held only while stalled
	always_ff @(posedge clock) begin
		if (reset) begin
			cmd.valid <= 1'b0;
		end else if (!stall) begin
			cmd.valid <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			cmd.base	<= base_val;
			cmd.kind	<= kind_val;
			cmd.window	<= window;
			cmd.length	<= length;
			cmd.mask	<= mask;
		end
	end

	// One command per request, never back to back
	a_valid_pulse: assert property (@(posedge clock) disable iff (reset)
		cmd.valid && !stall |=> !cmd.valid);

endmodule

/* index_cmd_if.sv */
interface index_cmd_if
	import pkg_index::*;
();

	logic		valid;		// One cycle per accepted request
	req_kind_t	kind;
	index_t		base;		// Computed base index
	index_t		window;
	index_t		length;
	mask_t		mask;

	modport arith (
		output valid, kind, base, window, length, mask
	);

	modport gen (
		input valid, kind, base, window, length, mask
	);

	// Merge only needs the single-index path
	modport merge (
		input valid, kind, base
	);

endinterface

/* index_merge.sv */
module index_merge
	import pkg_index::*;
(
	input	logic			clock,
	input	logic			reset,
	input	logic			stall,
	index_cmd_if.merge		cmd,
	input	logic			slice_valid,
	input	logic			slice_last,
	input	logic			slice_busy,
	input	index_t			slice_index,
	input	logic			skip_valid,
	input	logic			skip_last,
	input	logic			skip_busy,
	input	index_t			skip_index,
	output	logic			out_req,
	output	logic			out_slice,
	output	logic			out_last,
	output	logic			busy,
	output	index_t			out_index
);

	logic		pend_single;		// Single index waiting for output
	index_t		single_base;
	logic		out_req_r;
	logic		out_last_r;

	// Stalled cycles show no request
	assign out_req	= out_req_r & ~stall;
	assign out_last	= out_last_r & ~stall;

	assign busy	= cmd.valid | pend_single | slice_busy | skip_busy | out_req_r;

	always_ff @(posedge clock) begin
		if (reset) begin
			pend_single	<= 1'b0;
			out_req_r	<= 1'b0;
			out_last_r	<= 1'b0;
			out_slice	<= 1'b0;
		end else if (!stall) begin
			pend_single	<= cmd.valid & (cmd.kind == KIND_SINGLE);
			out_req_r	<= pend_single | slice_valid | skip_valid;
			out_last_r	<= pend_single | (slice_valid & slice_last) | (skip_valid & skip_last);
			out_slice	<= slice_valid | skip_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			single_base	<= cmd.base;
			out_index	<= pend_single ? single_base :
							slice_valid ? slice_index : skip_index;
		end
	end

	// Only one generator runs per command
	a_one_gen: assert property (@(posedge clock) disable iff (reset)
		!(slice_valid && skip_valid));

endmodule

/* index_unit.f */
pkg_index.sv
index_cmd_if.sv
index_arith.sv
slice_seq.sv
skip_ctrl.sv
index_merge.sv
index_unit.sv
tb_index_unit.sv

/* index_unit.sv */
module index_unit
	import pkg_index::*;
(
	input	logic			clock,
	input	logic			reset,
	input	logic			stall,
	input	logic			req,
	input	logic			masked_read,
	input	logic			slice,
	input	index_src_t		sel_a,
	input	index_src_t		sel_b,
	input	index_src_t		sel_c,
	input	logic			swap,
	input	logic			sign,
	input	index_t			index,
	input	index_t			window,
	input	index_t			length,
	input	index_t			lane_id,
	input	index_t			thread_id,
	input	index_t			constant,
	input	mask_t			mask,
	output	logic			out_req,
	output	logic			out_slice,
	output	logic			out_last,
	output	logic			busy,
	output	index_t			out_index
);

	logic		slice_valid;
	logic		slice_last;
	logic		slice_busy;
	index_t		slice_index;
	logic		skip_valid;
	logic		skip_last;
	logic		skip_busy;
	index_t		skip_index;

	index_cmd_if u_cmd ();

	index_arith u_arith (
		.clock(clock), .reset(reset), .stall(stall), .req(req),
		.masked_read(masked_read), .slice(slice), .busy(busy),
		.sel_a(sel_a), .sel_b(sel_b), .sel_c(sel_c), .swap(swap), .sign(sign),
		.index(index), .window(window), .length(length), .lane_id(lane_id),
		.thread_id(thread_id), .constant(constant), .mask(mask), .cmd(u_cmd.arith)
	);

	slice_seq u_slice (
		.clock(clock), .reset(reset), .stall(stall), .cmd(u_cmd.gen),
		.gen_valid(slice_valid), .gen_last(slice_last),
		.gen_busy(slice_busy), .gen_index(slice_index)
	);

	skip_ctrl u_skip (
		.clock(clock), .reset(reset), .stall(stall), .cmd(u_cmd.gen),
		.gen_valid(skip_valid), .gen_last(skip_last),
		.gen_busy(skip_busy), .gen_index(skip_index)
	);

	index_merge u_merge (
		.clock(clock), .reset(reset), .stall(stall), .cmd(u_cmd.merge),
		.slice_valid(slice_valid), .slice_last(slice_last), .slice_busy(slice_busy),
		.slice_index(slice_index), .skip_valid(skip_valid), .skip_last(skip_last),
		.skip_busy(skip_busy), .skip_index(skip_index), .out_req(out_req),
		.out_slice(out_slice), .out_last(out_last), .busy(busy), .out_index(out_index)
	);

endmodule

/* pkg_index.sv */
package pkg_index;

	//////////////////////////////
	// Widths
	//////////////////////////////

	localparam int WIDTH_INDEX		= 8;	// Index, ID and constant width
	localparam int WIDTH_MASK		= 16;	// Number of mask bits
	localparam int WIDTH_MASK_SEL	= $clog2(WIDTH_MASK);

	//////////////////////////////
	// Types
	//////////////////////////////

	typedef logic [WIDTH_INDEX-1:0]		index_t;
	typedef logic [WIDTH_MASK-1:0]		mask_t;		// Bit p enables offset p
	typedef logic [WIDTH_MASK_SEL-1:0]	mask_sel_t;

	// Operand sources for a*b+c
	typedef enum logic [2:0] {
		SRC_ZERO,
		SRC_THREAD,
		SRC_LANE,
		SRC_CONST,
		SRC_ORIG		// Index of the request itself
	} index_src_t;

	// How one request expands into indices
	typedef enum logic [1:0] {
		KIND_SINGLE,
		KIND_SLICE,
		KIND_MASKED
	} req_kind_t;

endpackage

/* skip_ctrl.sv */
module skip_ctrl
	import pkg_index::*;
(
	input	logic			clock,
	input	logic			reset,
	input	logic			stall,
	index_cmd_if.gen		cmd,
	output	logic			gen_valid,
	output	logic			gen_last,
	output	logic			gen_busy,
	output	index_t			gen_index
);

	logic		load;
	mask_t		len_mask;		// Bits below length
	mask_t		rem_mask;		// Bits still to be emitted
	mask_t		rem_next;
	mask_sel_t	sel;			// Lowest set bit
	index_t		base_r;

	assign load	= cmd.valid & ~stall & (cmd.kind == KIND_MASKED);

	always_comb begin
		len_mask = '0;
		for (int p = 0; p < WIDTH_MASK; p++) begin
			len_mask[p] = (index_t'(p) < cmd.length);
		end
	end

	//////////////////////////////
	// Priority encoder
	//////////////////////////////

	// Scan downwards so the lowest set bit wins
	always_comb begin
		sel = '0;
		for (int p = WIDTH_MASK - 1; p >= 0; p--) begin
			if (rem_mask[p]) begin
				sel = WIDTH_MASK_SEL'(p);
			end
		end
	end

	assign rem_next		= rem_mask & (rem_mask - 1'b1);	// Clear lowest bit

	assign gen_busy		= (rem_mask != '0);
	assign gen_valid	= gen_busy & ~stall;
	assign gen_index	= base_r + index_t'(sel);
	assign gen_last		= (rem_next == '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			rem_mask <= '0;
		end else if (load) begin
			rem_mask <= cmd.mask & len_mask;	// May be empty
		end else if (gen_valid) begin
			rem_mask <= rem_next;
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			base_r <= cmd.base;
		end
	end

	// Mask drains completely after the last element
	a_last_drains: assert property (@(posedge clock) disable iff (reset)
		gen_valid && gen_last |=> !gen_busy);

endmodule

/* slice_seq.sv */
module slice_seq
	import pkg_index::*;
(
	input	logic			clock,
	input	logic			reset,
	input	logic			stall,
	index_cmd_if.gen		cmd,
	output	logic			gen_valid,
	output	logic			gen_last,
	output	logic			gen_busy,
	output	index_t			gen_index
);

	logic		active;
	logic		load;
	logic		wrap;
	index_t		count;		// Element number within the slice
	index_t		offset;		// Position inside the window
	index_t		base_r;
	index_t		window_r;
	index_t		length_r;

	assign load		= cmd.valid & ~stall & (cmd.kind == KIND_SLICE);
	assign wrap		= (offset == window_r - 1'b1);

	assign gen_busy		= active;
	assign gen_valid	= active & ~stall;
	assign gen_index	= base_r + offset;
	assign gen_last		= (count == length_r - 1'b1);

	//////////////////////////////
	// Element and window counters
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			active	<= 1'b0;
			count	<= '0;
			offset	<= '0;
		end else if (load) begin
			active	<= 1'b1;
			count	<= '0;
			offset	<= '0;
		end else if (gen_valid) begin
			if (gen_last) begin
				active	<= 1'b0;		// Slice done
			end
			count	<= count + 1'b1;
			offset	<= wrap ? '0 : offset + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			base_r		<= cmd.base;
			window_r	<= cmd.window;
			length_r	<= cmd.length;
		end
	end

	// Offset always stays inside the window
	a_offset_range: assert property (@(posedge clock) disable iff (reset)
		gen_valid |-> gen_busy && (offset < window_r));

endmodule

/* tb_index_unit.sv */
module tb_index_unit;
	import pkg_index::*;

	localparam int NUM_REQS	= 28;
	localparam int TIMEOUT	= 60 * NUM_REQS + 100;	// Cycles for the whole run

	logic		clock, reset, stall, req, masked_read, slice, swap, sign;
	index_src_t	sel_a, sel_b, sel_c;
	index_t		index, window, length, lane_id, thread_id, constant;
	mask_t		mask;
	logic		out_req, out_slice, out_last, busy;
	index_t		out_index;

	integer		seed = 32'h6a6c1ada;
	int			cycles, checks, errors, seq_seen, seq_exp;
	index_t		got_index[$], exp_index[$];
	logic		got_slice[$], exp_slice[$], got_last[$], exp_last[$];

	index_unit u_dut (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// Output monitor and run limit
	always @(posedge clock) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("Run did not finish within %0d cycles", TIMEOUT);
			$display("SIMULATION FAILED");
			$finish;
		end else if (out_req) begin
			assert (!stall) else begin
				$display("Output request seen during stall at %0t", $time);
				errors++;
			end
			got_index.push_back(out_index);
			got_slice.push_back(out_slice);
			got_last.push_back(out_last);
			seq_seen += out_last;
		end
	end

	function automatic index_t operand(input index_src_t src);
		case (src)
			SRC_THREAD:	return thread_id;
			SRC_LANE:	return lane_id;
			SRC_CONST:	return constant;
			SRC_ORIG:	return index;
			default:	return '0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] got);
		checks++;
		assert (exp === got) else begin
			$display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
			errors++;
		end
	endtask

	//////////////////////////////
	// One request and its check
	//////////////////////////////

	task automatic run_request(input logic mr, input logic sl, input index_t win, input index_t len,
		input mask_t msk, input int stall_at, input int stall_len, input bit again);
		index_t	a, b, c, base;
		int		last_p;
		got_index.delete();
		got_slice.delete();
		got_last.delete();
		exp_index.delete();
		exp_slice.delete();
		exp_last.delete();
		@(negedge clock);
		while (busy) @(negedge clock);
		thread_id	= $random(seed);
		lane_id		= $random(seed);
		constant	= $random(seed);
		index		= $random(seed);
		a = operand(sel_a);
		b = operand(sel_b);
		c = operand(sel_c);
		base = !sign ? a * b + c : (swap ? c - a * b : a * b - c);	// Modulo 256
		if (mr) begin		// Masked beats slice
			for (int p = 0; p < WIDTH_MASK; p++)
				if (msk[p] && p < len) last_p = p;
			for (int p = 0; p < WIDTH_MASK; p++)
				if (msk[p] && p < len) begin
					exp_index.push_back(base + p);
					exp_slice.push_back(1'b1);
					exp_last.push_back(p == last_p);
				end
		end else if (sl) begin
			for (int k = 0; k < len; k++) begin
				exp_index.push_back(base + k % win);
				exp_slice.push_back(1'b1);
				exp_last.push_back(k == len - 1);
			end
		end else begin
			exp_index.push_back(base);
			exp_slice.push_back(1'b0);
			exp_last.push_back(1'b1);
		end
		seq_exp += (exp_index.size() > 0);
		masked_read = mr;
		slice = sl;
		window = win;
		length = len;
		mask = msk;
		req = 1'b1;
		@(negedge clock);
		req = 1'b0;
		if (again) begin		// Second request while busy must be dropped
			@(negedge clock);
			{req, masked_read, slice} = 3'b100;
			@(negedge clock);
			req = 1'b0;
		end
		if (stall_len > 0) begin
			repeat (stall_at) @(negedge clock);
			stall = 1'b1;
			repeat (stall_len) @(negedge clock);
			stall = 1'b0;
		end
		while (busy) @(negedge clock);
		checks++;
		assert (got_index.size() == exp_index.size()) else begin
			$display("Request done at %0t gave %0d outputs instead of %0d",
				$time, got_index.size(), exp_index.size());
			errors++;
		end
		for (int i = 0; i < got_index.size() && i < exp_index.size(); i++) begin
			check_value("out_index", exp_index[i], got_index[i]);
			check_value("out_slice", exp_slice[i], got_slice[i]);
			check_value("out_last", exp_last[i], got_last[i]);
		end
	endtask

	task automatic test_single();
		int err0;
		err0 = errors;
		for (int f = 0; f < 3; f++)
			for (int s = 0; s < 5; s++) begin
				sel_a = index_src_t'(s);
				sel_b = index_src_t'((s + 1) % 5);
				sel_c = index_src_t'((s + 3) % 5);
				sign = (f != 0);
				swap = (f == 2);
				run_request(1'b0, 1'b0, 8'd1, 8'd1, '0, 0, 0, 1'b0);
			end
		$display("single: 15 requests, %0d errors", errors - err0);
	endtask

	task automatic test_expand();
		int err0;
		err0 = errors;
		sel_a = SRC_THREAD;
		sel_b = SRC_LANE;
		sel_c = SRC_CONST;
		sign = 1'b0;
		swap = 1'b0;
		run_request(1'b0, 1'b1, 8'd3, 8'd8, '0, 0, 0, 1'b0);
		run_request(1'b0, 1'b1, 8'd8, 8'd8, '0, 0, 0, 1'b0);
		$display("slice: 2 requests, %0d errors", errors - err0);
		err0 = errors;
		for (int i = 0; i < 4; i++)
			run_request(1'b1, i == 2, 8'd1, 8'd16, mask_t'($random(seed)), 0, 0, 1'b0);
		for (int i = 0; i < 2; i++)
			run_request(1'b1, 1'b0, 8'd1, 8'd5, mask_t'($random(seed)), 0, 0, 1'b0);
		$display("masked: 6 requests, %0d errors", errors - err0);
		err0 = errors;
		run_request(1'b1, 1'b0, 8'd1, 8'd5, 16'hffe0, 0, 0, 1'b0);
		run_request(1'b1, 1'b0, 8'd1, 8'd16, 16'h0000, 0, 0, 1'b0);
		$display("empty mask: 2 requests, %0d errors", errors - err0);
		err0 = errors;
		run_request(1'b0, 1'b1, 8'd3, 8'd8, '0, 3, 4, 1'b0);
		run_request(1'b1, 1'b0, 8'd1, 8'd16, 16'hb5a6, 4, 3, 1'b0);
		$display("stall: 2 requests, %0d errors", errors - err0);
		err0 = errors;
		run_request(1'b0, 1'b1, 8'd2, 8'd6, '0, 0, 0, 1'b1);
		checks++;
		assert (seq_seen == seq_exp) else begin
			$display("Saw %0d sequences for %0d accepted requests", seq_seen, seq_exp);
			errors++;
		end
		$display("busy: 1 request, %0d errors", errors - err0);
	endtask

	initial begin
		{reset, stall, req, masked_read, slice, swap, sign} = 7'b1000000;
		sel_a = SRC_ZERO;
		sel_b = SRC_ZERO;
		sel_c = SRC_ZERO;
		{index, window, length, lane_id, thread_id, constant, mask} = '0;
		repeat (4) @(negedge clock);
		reset = 1'b0;
		check_value("out_req", 1'b0, out_req);
		check_value("out_last", 1'b0, out_last);
		check_value("busy", 1'b0, busy);
		$display("reset: %0d errors", errors);
		test_single();
		test_expand();
		$display("Tests: 7, checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
